// ==== Bender.yml ====
package:
  name: accel_controller

sources:
  - include_dirs:
      - design
    files:
      - design/accel_ctrl_pkg.sv
      - design/buffer_init_writer.sv
      - design/serial_conv_stage.sv
      - design/systolic_conv_stage.sv
      - design/display_stage.sv
      - design/accel_controller.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/accel_controller_assert.sv
      - tb/accel_controller_tb.sv

// ==== design/accel_controller.sv ====
`timescale 1ns/1ps

module accel_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_sa,
    input  logic                       serial_mode_done,
    input  logic                       weight_preloader_done,
    input  logic                       feature_loader_done,
    input  logic                       display_done,
    output accel_ctrl_pkg::mem_wr_t    mem_wr,
    output accel_ctrl_pkg::comp_ctrl_t comp_ctrl,
    output accel_ctrl_pkg::disp_ctrl_t disp_ctrl
);
    import accel_ctrl_pkg::*;

    logic       run;
    logic       init_go;
    logic       init_last;
    logic       init_comp_rst;
    logic       serial_last;
    logic       systolic_last;
    logic       disp_last;
    logic       disp_mem_sel;
    comp_ctrl_t serial_comp;
    comp_ctrl_t systolic_comp;

    // ##############################
    // run flag

    assign init_go = start_sa && !run; // ignored mid-run.

    always_ff @(posedge clk) begin
        if (!rst)
            run <= 1'b0;
        else if (init_go)
            run <= 1'b1;
        else if (disp_last)
            run <= 1'b0;
    end

    // ##############################
    // phase chain

    buffer_init_writer u_init (
        .clk      (clk),
        .rst      (rst),
        .go       (init_go),
        .last     (init_last),
        .mem_wr   (mem_wr),
        .comp_rst (init_comp_rst)
    );

    serial_conv_stage u_serial (
        .clk              (clk),
        .rst              (rst),
        .go               (init_last),
        .serial_mode_done (serial_mode_done),
        .last             (serial_last),
        .comp_ctrl        (serial_comp)
    );

    systolic_conv_stage u_systolic (
        .clk                   (clk),
        .rst                   (rst),
        .go                    (serial_last),
        .weight_preloader_done (weight_preloader_done),
        .feature_loader_done   (feature_loader_done),
        .last                  (systolic_last),
        .comp_ctrl             (systolic_comp)
    );

    display_stage u_display (
        .clk          (clk),
        .rst          (rst),
        .go           (systolic_last),
        .display_done (display_done),
        .last         (disp_last),
        .mem_sel      (disp_mem_sel),
        .disp_ctrl    (disp_ctrl)
    );

    // only one stage is active, so OR of the idle-zero fields is safe.
    always_comb begin
        comp_ctrl = comp_ctrl_t'(serial_comp | systolic_comp);
        comp_ctrl.rst_computation_module = init_comp_rst
                                         & serial_comp.rst_computation_module
                                         & systolic_comp.rst_computation_module;
        comp_ctrl.mem_sel = serial_comp.mem_sel | systolic_comp.mem_sel | disp_mem_sel;
    end

endmodule

// ==== design/accel_ctrl_defines.svh ====
`ifndef ACCEL_CTRL_DEFINES_SVH
`define ACCEL_CTRL_DEFINES_SVH

// operand memory address width.
`define ADDR_W 6
// operand word width.
`define DATA_W 8

// kernel side.
`define WEIGHT_DIM 3
// feature map side.
`define FEATURE_DIM 4
// first feature word after the kernel.
`define FEATURE_BASE 9

// strides per mode.
`define STRIDE_CNT 4
// cycles after the last serial stride.
`define SERIAL_TAIL 2
// systolic drain cycles.
`define DRAIN_CNT 3

`endif

// ==== design/accel_ctrl_pkg.sv ====
`include "accel_ctrl_defines.svh"

package accel_ctrl_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [$clog2(`STRIDE_CNT)-1:0] stride_idx_t;

    typedef enum logic [1:0] {
        MODE_SERIAL   = 2'b00,
        MODE_SYSTOLIC = 2'b01
    } comp_mode_e;

    typedef struct packed {
        logic              we;
        addr_t             addr;
        logic [`DATA_W-1:0] data;
    } mem_wr_t;

    typedef struct packed {
        logic        rst_computation_module; // active low.
        logic        mem_sel;
        comp_mode_e  computation_mode_sel;
        logic        serial_mode_en;
        addr_t       serial_feature_baseaddr;
        logic        weight_preloader_en;
        logic        feature_loader_en;
        logic        systolic_mode;
        addr_t       systolic_feature_baseaddr;
        stride_idx_t c_reg_sel; // result register c11..c22.
    } comp_ctrl_t;

    typedef struct packed {
        logic rst_display_module; // active low.
        logic display_mode_en;
    } disp_ctrl_t;

    // ##############################
    // idle words

    localparam mem_wr_t MEM_WR_IDLE = '{we: 1'b0, addr: '0, data: '0};

    localparam comp_ctrl_t COMP_IDLE = '{
        rst_computation_module:    1'b1,
        mem_sel:                   1'b0,
        computation_mode_sel:      MODE_SERIAL,
        serial_mode_en:            1'b0,
        serial_feature_baseaddr:   '0,
        weight_preloader_en:       1'b0,
        feature_loader_en:         1'b0,
        systolic_mode:             1'b0,
        systolic_feature_baseaddr: '0,
        c_reg_sel:                 '0
    };

    localparam disp_ctrl_t DISP_IDLE = '{rst_display_module: 1'b1, display_mode_en: 1'b0};

    // top-left corner of the kernel window for stride k.
    function automatic addr_t stride_base(input stride_idx_t k);
        int unsigned win_per_row;
        int unsigned row;
        int unsigned col;
        win_per_row = `FEATURE_DIM - `WEIGHT_DIM + 1;
        row = k / win_per_row;
        col = k % win_per_row;
        return addr_t'(`FEATURE_BASE + row * `FEATURE_DIM + col);
    endfunction

endpackage

// ==== design/buffer_init_writer.sv ====
`timescale 1ns/1ps
`include "accel_ctrl_defines.svh"

module buffer_init_writer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    go,
    output logic                    last,
    output accel_ctrl_pkg::mem_wr_t mem_wr,
    output logic                    comp_rst
);
    import accel_ctrl_pkg::*;

    localparam int LAST_ADDR = `FEATURE_BASE + `FEATURE_DIM * `FEATURE_DIM - 1;
    localparam int IDX_W     = $clog2(`FEATURE_DIM);

    logic             active;
    addr_t            cnt;
    logic [IDX_W-1:0] row;
    logic [IDX_W-1:0] col;
    logic             in_weights;

    assign in_weights = (cnt < addr_t'(`FEATURE_BASE));
    assign last       = active && (cnt == addr_t'(LAST_ADDR));
    assign comp_rst   = ~last; // clear the datapath on the final write.

    always_ff @(posedge clk) begin
        if (!rst) begin
            active <= 1'b0;
            cnt    <= '0;
            row    <= '0;
            col    <= '0;
        end else if (go) begin
            active <= 1'b1;
            cnt    <= '0;
            row    <= '0;
            col    <= '0;
        end else if (active) begin
            cnt <= cnt + 1'b1;
            if (last)
                active <= 1'b0;
            if (cnt == addr_t'(`FEATURE_BASE - 1)) begin
                row <= '0; // feature map starts at its origin.
                col <= '0;
            end else if (in_weights) begin
                if (row == IDX_W'(`WEIGHT_DIM - 1)) begin // column-major.
                    row <= '0;
                    col <= col + 1'b1;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                if (col == IDX_W'(`FEATURE_DIM - 1)) begin // row-major.
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_comb begin
        mem_wr = MEM_WR_IDLE;
        if (active) begin
            mem_wr.we   = 1'b1;
            mem_wr.addr = cnt;
            mem_wr.data = `DATA_W'(col) + 1'b1;
        end
    end

endmodule

// ==== design/display_stage.sv ====
`timescale 1ns/1ps

module display_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       go,
    input  logic                       display_done,
    output logic                       last,
    output logic                       mem_sel,
    output accel_ctrl_pkg::disp_ctrl_t disp_ctrl
);
    import accel_ctrl_pkg::*;

    typedef enum logic [1:0] {
        D_IDLE,
        D_ENABLE,
        D_WAIT,
        D_CLOSE
    } state_e;

    state_e state;

    assign last    = (state == D_CLOSE);
    assign mem_sel = (state == D_ENABLE);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= D_IDLE;
        end else begin
            case (state)
                D_IDLE:   if (go) state <= D_ENABLE;
                D_ENABLE: state <= D_WAIT;
                D_WAIT:   if (display_done) state <= D_CLOSE;
                default:  state <= D_IDLE;
            endcase
        end
    end

    always_comb begin
        disp_ctrl = DISP_IDLE;
        if (state == D_ENABLE || state == D_WAIT)
            disp_ctrl.rst_display_module = 1'b0; // held in reset while drawing.
        if (state == D_ENABLE)
            disp_ctrl.display_mode_en = 1'b1;
    end

endmodule

// ==== design/serial_conv_stage.sv ====
`timescale 1ns/1ps
`include "accel_ctrl_defines.svh"

module serial_conv_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       go,
    input  logic                       serial_mode_done,
    output logic                       last,
    output accel_ctrl_pkg::comp_ctrl_t comp_ctrl
);
    import accel_ctrl_pkg::*;

    localparam int TAIL_W = $clog2(`SERIAL_TAIL + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_STRIDE,
        S_TAIL
    } state_e;

    state_e            state;
    stride_idx_t       stride;
    logic [TAIL_W-1:0] tail;

    assign last = (state == S_TAIL) && (tail == TAIL_W'(`SERIAL_TAIL - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state  <= S_IDLE;
            stride <= '0;
            tail   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (go) begin
                        state  <= S_STRIDE;
                        stride <= '0;
                    end
                end
                S_STRIDE: begin
                    if (serial_mode_done) begin
                        if (stride == stride_idx_t'(`STRIDE_CNT - 1)) begin
                            state <= S_TAIL;
                            tail  <= '0;
                        end else begin
                            stride <= stride + 1'b1;
                        end
                    end
                end
                S_TAIL: begin
                    if (last)
                        state <= S_IDLE;
                    else
                        tail <= tail + 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ##############################
    // control word

    always_comb begin
        comp_ctrl = COMP_IDLE;
        if (state != S_IDLE) begin
            comp_ctrl.rst_computation_module = 1'b0;
            comp_ctrl.mem_sel                = 1'b1;
            comp_ctrl.computation_mode_sel   = MODE_SERIAL;
        end
        if (state == S_STRIDE) begin
            comp_ctrl.serial_mode_en          = 1'b1;
            comp_ctrl.serial_feature_baseaddr = stride_base(stride);
        end
    end

endmodule

// ==== design/systolic_conv_stage.sv ====
`timescale 1ns/1ps
`include "accel_ctrl_defines.svh"

module systolic_conv_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       go,
    input  logic                       weight_preloader_done,
    input  logic                       feature_loader_done,
    output logic                       last,
    output accel_ctrl_pkg::comp_ctrl_t comp_ctrl
);
    import accel_ctrl_pkg::*;

    localparam int DRAIN_W = $clog2(`DRAIN_CNT + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_PRELOAD,
        S_STRIDE,
        S_DRAIN
    } state_e;

    state_e             state;
    stride_idx_t        stride;
    logic [DRAIN_W-1:0] drain;

    assign last = (state == S_DRAIN) && (drain == DRAIN_W'(`DRAIN_CNT - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            state  <= S_IDLE;
            stride <= '0;
            drain  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (go)
                        state <= S_PRELOAD;
                end
                S_PRELOAD: begin
                    if (weight_preloader_done) begin
                        state  <= S_STRIDE;
                        stride <= '0;
                    end
                end
                S_STRIDE: begin
                    if (feature_loader_done) begin
                        if (stride == stride_idx_t'(`STRIDE_CNT - 1)) begin
                            state <= S_DRAIN;
                            drain <= '0;
                        end else begin
                            stride <= stride + 1'b1;
                        end
                    end
                end
                S_DRAIN: begin
                    if (last)
                        state <= S_IDLE;
                    else
                        drain <= drain + 1'b1;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ##############################
    // control word

    always_comb begin
        comp_ctrl = COMP_IDLE;
        if (state != S_IDLE) begin
            comp_ctrl.rst_computation_module = 1'b0;
            comp_ctrl.mem_sel                = 1'b1;
            comp_ctrl.computation_mode_sel   = MODE_SYSTOLIC;
        end
        case (state)
            S_PRELOAD: begin
                comp_ctrl.weight_preloader_en = 1'b1;
            end
            S_STRIDE: begin
                comp_ctrl.feature_loader_en         = 1'b1;
                comp_ctrl.systolic_mode             = 1'b1;
                comp_ctrl.systolic_feature_baseaddr = stride_base(stride);
                comp_ctrl.c_reg_sel                 = stride; // one result reg per window.
            end
            S_DRAIN: begin
                comp_ctrl.systolic_mode = 1'b1; // flush the array.
            end
            default: ;
        endcase
    end

endmodule

// ==== tb/accel_controller_assert.sv ====
`timescale 1ns/1ps

module accel_controller_assert (
    input logic                       clk,
    input logic                       rst,
    input accel_ctrl_pkg::mem_wr_t    mem_wr,
    input accel_ctrl_pkg::comp_ctrl_t comp_ctrl,
    input accel_ctrl_pkg::disp_ctrl_t disp_ctrl
);

    logic comp_busy;
    int   fail_cnt = 0;

    assign comp_busy = comp_ctrl.serial_mode_en | comp_ctrl.weight_preloader_en
                     | comp_ctrl.feature_loader_en | comp_ctrl.systolic_mode;

    // the fill phase owns the memory alone.
    wr_excludes_comp: assert property (@(posedge clk) disable iff (!rst)
        mem_wr.we |-> !comp_busy)
        else begin
            fail_cnt++;
            $error("memory write strobe high together with a computation enable");
        end

    serial_excludes_feature: assert property (@(posedge clk) disable iff (!rst)
        !(comp_ctrl.serial_mode_en && comp_ctrl.feature_loader_en))
        else begin
            fail_cnt++;
            $error("serial_mode_en and feature_loader_en both high");
        end

    display_single_pulse: assert property (@(posedge clk) disable iff (!rst)
        disp_ctrl.display_mode_en |=> !disp_ctrl.display_mode_en)
        else begin
            fail_cnt++;
            $error("display_mode_en high for two consecutive cycles");
        end

endmodule

bind accel_controller accel_controller_assert u_assert (
    .clk       (clk),
    .rst       (rst),
    .mem_wr    (mem_wr),
    .comp_ctrl (comp_ctrl),
    .disp_ctrl (disp_ctrl)
);

// ==== tb/accel_controller_tb.sv ====
`timescale 1ns/1ps
`include "accel_ctrl_defines.svh"

module accel_controller_tb;
    import accel_ctrl_pkg::*;

    localparam int NUM_ROWS = 6;
    localparam int FILL_CNT = `FEATURE_BASE + `FEATURE_DIM * `FEATURE_DIM;
    localparam int IDLE_GAP = 3;

    // top-left window corners on the 4x4 map.
    localparam addr_t CORNER [`STRIDE_CNT] = '{6'd9, 6'd10, 6'd13, 6'd14};

    typedef struct packed {
        logic [3:0][3:0] serial;
        logic [3:0]      preload;
        logic [3:0][3:0] feature;
        logic [3:0]      display;
    } delays_t;

    typedef struct packed {
        logic start_sa;
        logic serial_mode_done;
        logic weight_preloader_done;
        logic feature_loader_done;
        logic display_done;
    } stim_t;

    logic       clk;
    logic       rst;
    logic       start_sa;
    logic       serial_mode_done;
    logic       weight_preloader_done;
    logic       feature_loader_done;
    logic       display_done;
    mem_wr_t    mem_wr;
    comp_ctrl_t comp_ctrl;
    disp_ctrl_t disp_ctrl;

    string   row_name [NUM_ROWS];
    delays_t row_dly  [NUM_ROWS];
    integer  seed;
    string   cur_test;
    int      cycle_cnt    = 0;
    int      cycle_limit  = 0;
    int      checks       = 0;
    int      errs         = 0;
    int      test_errs    = 0;
    int      test_cycles  = 0;
    int      tests_run    = 0;
    int      tests_failed = 0;

    accel_controller dut0 (
        .clk                   (clk),
        .rst                   (rst),
        .start_sa              (start_sa),
        .serial_mode_done      (serial_mode_done),
        .weight_preloader_done (weight_preloader_done),
        .feature_loader_done   (feature_loader_done),
        .display_done          (display_done),
        .mem_wr                (mem_wr),
        .comp_ctrl             (comp_ctrl),
        .disp_ctrl             (disp_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ##############################
    // expected words

    function automatic mem_wr_t idle_mem();
        mem_wr_t w;
        w = '0;
        return w;
    endfunction

    function automatic comp_ctrl_t idle_comp();
        comp_ctrl_t c;
        c = '0;
        c.rst_computation_module = 1'b1; // active low.
        c.computation_mode_sel   = MODE_SERIAL;
        return c;
    endfunction

    function automatic disp_ctrl_t idle_disp();
        disp_ctrl_t d;
        d.rst_display_module = 1'b1;
        d.display_mode_en    = 1'b0;
        return d;
    endfunction

    function automatic mem_wr_t fill_word(input int a);
        mem_wr_t w;
        int      col;
        if (a < `FEATURE_BASE)
            col = a / `WEIGHT_DIM; // weights column-major.
        else
            col = (a - `FEATURE_BASE) % `FEATURE_DIM; // features row-major.
        w.we   = 1'b1;
        w.addr = addr_t'(a);
        w.data = `DATA_W'(col + 1);
        return w;
    endfunction

    function automatic logic [3:0] rand_delay();
        return 4'({$random(seed)} % 5);
    endfunction

    function automatic int delay_sum(input delays_t d);
        int s;
        int k;
        s = d.preload + d.display;
        for (k = 0; k < `STRIDE_CNT; k++)
            s = s + d.serial[k] + d.feature[k];
        return s;
    endfunction

    // ##############################
    // checks

    task automatic check_mem_wr(input mem_wr_t exp, input mem_wr_t act);
        checks++;
        if (act !== exp) begin
            errs++;
            test_errs++;
            $display("CHECK FAILED %s mem_wr cycle %0d: expected %h, actual %h",
                     cur_test, test_cycles, exp, act);
        end
    endtask

    task automatic check_comp_ctrl(input comp_ctrl_t exp, input comp_ctrl_t act);
        checks++;
        if (act !== exp) begin
            errs++;
            test_errs++;
            $display("CHECK FAILED %s comp_ctrl cycle %0d: expected %h, actual %h",
                     cur_test, test_cycles, exp, act);
        end
    endtask

    task automatic check_disp_ctrl(input disp_ctrl_t exp, input disp_ctrl_t act);
        checks++;
        if (act !== exp) begin
            errs++;
            test_errs++;
            $display("CHECK FAILED %s disp_ctrl cycle %0d: expected %h, actual %h",
                     cur_test, test_cycles, exp, act);
        end
    endtask

    // drive this cycle's inputs, then compare mid-cycle.
    task automatic tick(input mem_wr_t em, input comp_ctrl_t ec, input disp_ctrl_t ed,
                        input stim_t s);
        @(posedge clk);
        start_sa              <= s.start_sa;
        serial_mode_done      <= s.serial_mode_done;
        weight_preloader_done <= s.weight_preloader_done;
        feature_loader_done   <= s.feature_loader_done;
        display_done          <= s.display_done;
        @(negedge clk);
        check_mem_wr(em, mem_wr);
        check_comp_ctrl(ec, comp_ctrl);
        check_disp_ctrl(ed, disp_ctrl);
        test_cycles++;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errs   = 0;
        test_cycles = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs != 0)
            tests_failed++;
        $display("test %-10s %s, %0d cycles, %0d mismatches", cur_test,
                 (test_errs == 0) ? "ok" : "failed", test_cycles, test_errs);
    endtask

    // ##############################
    // one full run

    task automatic run_row(input delays_t d);
        stim_t      s;
        comp_ctrl_t phase;
        comp_ctrl_t ec;
        disp_ctrl_t ed;
        int         a;
        int         k;
        int         i;
        s = '0;
        s.start_sa = 1'b1;
        tick(idle_mem(), idle_comp(), idle_disp(), s);
        for (a = 0; a < FILL_CNT; a++) begin
            s = '0;
            s.start_sa = (a == 10); // mid-run start is ignored.
            ec = idle_comp();
            ec.rst_computation_module = (a != FILL_CNT - 1);
            tick(fill_word(a), ec, idle_disp(), s);
        end
        phase = idle_comp();
        phase.rst_computation_module = 1'b0;
        phase.mem_sel                = 1'b1;
        for (k = 0; k < `STRIDE_CNT; k++) begin
            for (i = 0; i <= d.serial[k]; i++) begin
                s = '0;
                s.serial_mode_done = (i == d.serial[k]);
                ec = phase;
                ec.serial_mode_en          = 1'b1;
                ec.serial_feature_baseaddr = CORNER[k];
                tick(idle_mem(), ec, idle_disp(), s);
            end
        end
        for (i = 0; i < `SERIAL_TAIL; i++)
            tick(idle_mem(), phase, idle_disp(), stim_t'(0));
        phase.computation_mode_sel = MODE_SYSTOLIC;
        for (i = 0; i <= d.preload; i++) begin
            s = '0;
            s.weight_preloader_done = (i == d.preload);
            ec = phase;
            ec.weight_preloader_en = 1'b1;
            tick(idle_mem(), ec, idle_disp(), s);
        end
        for (k = 0; k < `STRIDE_CNT; k++) begin
            for (i = 0; i <= d.feature[k]; i++) begin
                s = '0;
                s.feature_loader_done = (i == d.feature[k]);
                ec = phase;
                ec.feature_loader_en         = 1'b1;
                ec.systolic_mode             = 1'b1;
                ec.systolic_feature_baseaddr = CORNER[k];
                ec.c_reg_sel                 = stride_idx_t'(k);
                tick(idle_mem(), ec, idle_disp(), s);
            end
        end
        ec = phase;
        ec.systolic_mode = 1'b1;
        for (i = 0; i < `DRAIN_CNT; i++)
            tick(idle_mem(), ec, idle_disp(), stim_t'(0));
        ec = idle_comp();
        ec.mem_sel = 1'b1;
        ed = idle_disp();
        ed.rst_display_module = 1'b0;
        ed.display_mode_en    = 1'b1;
        tick(idle_mem(), ec, ed, stim_t'(0));
        ed.display_mode_en = 1'b0;
        for (i = 0; i <= d.display; i++) begin
            s = '0;
            s.display_done = (i == d.display);
            tick(idle_mem(), idle_comp(), ed, s);
        end
        s = '0;
        s.start_sa = 1'b1; // closing cycle still counts as running.
        tick(idle_mem(), idle_comp(), idle_disp(), s);
        for (i = 0; i < IDLE_GAP; i++)
            tick(idle_mem(), idle_comp(), idle_disp(), stim_t'(0));
    endtask

    task automatic fill_table();
        int r;
        row_name[0] = "all_zero";
        row_dly[0]  = '0;
        row_name[1] = "all_one";
        row_dly[1]  = {{4{4'd1}}, 4'd1, {4{4'd1}}, 4'd1};
        row_name[2] = "mixed_a";
        row_dly[2]  = {{4'd3, 4'd1, 4'd2, 4'd0}, 4'd2, {4'd0, 4'd3, 4'd0, 4'd1}, 4'd4};
        row_name[3] = "mixed_b";
        row_dly[3]  = {{4'd0, 4'd0, 4'd5, 4'd1}, 4'd0, {4'd2, 4'd0, 4'd4, 4'd0}, 4'd0};
        row_name[4] = "random_0";
        row_name[5] = "random_1";
        for (r = 4; r < NUM_ROWS; r++) begin
            row_dly[r].preload = rand_delay();
            row_dly[r].display = rand_delay();
            for (int k = 0; k < `STRIDE_CNT; k++) begin
                row_dly[r].serial[k]  = rand_delay();
                row_dly[r].feature[k] = rand_delay();
            end
        end
    endtask

    // ##############################
    // main sequence

    initial begin
        seed                  = 32'h7ea3;
        rst                   = 1'b0;
        start_sa              = 1'b0;
        serial_mode_done      = 1'b0;
        weight_preloader_done = 1'b0;
        feature_loader_done   = 1'b0;
        display_done          = 1'b0;
        fill_table();
        for (int r = 0; r < NUM_ROWS; r++)
            cycle_limit = cycle_limit + 40 + delay_sum(row_dly[r]);
        cycle_limit = cycle_limit * 2;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        begin_test("reset_idle");
        for (int i = 0; i < IDLE_GAP; i++)
            tick(idle_mem(), idle_comp(), idle_disp(), stim_t'(0));
        end_test();
        for (int r = 0; r < NUM_ROWS; r++) begin
            begin_test(row_name[r]);
            run_row(row_dly[r]);
            end_test();
        end
        $display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
                 tests_run, tests_failed, checks, errs, dut0.u_assert.fail_cnt);
        if (errs == 0 && tests_failed == 0 && dut0.u_assert.fail_cnt == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/accel_ctrl_pkg.sv
design/buffer_init_writer.sv
design/serial_conv_stage.sv
design/systolic_conv_stage.sv
design/display_stage.sv
design/accel_controller.sv
tb/accel_controller_assert.sv
tb/accel_controller_tb.sv
